// ==== all.f ====
logic/gl_matrix_pkg.sv
logic/gl_cmd_pkg.sv
logic/row_assembler.sv
logic/matrix_stack.sv
logic/matrix_ctrl.sv
logic/matrix_top.sv
sim/matrix_tb.sv

// ==== Makefile ====
# Verilator build for the matrix stack testbench
# override on the command line, e.g. make run DEPTH=4

VERILATOR ?= verilator
TOP       ?= matrix_tb
DEPTH     ?= 8
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       ?= $(BUILD_DIR)/V$(TOP)
PASS_STR  ?= TEST PASSED

.PHONY: all compile run clean

all: run

# build the simulator executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSTACK_DEPTH=$(DEPTH) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# run and decide the result from the printed output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/matrix_tb.sv ====
`timescale 1ns/1ps

module matrix_tb #(
    parameter int STACK_DEPTH = 8
);

    import gl_matrix_pkg::*;
    import gl_cmd_pkg::*;

    localparam int N_RAND    = 150;     // random commands in the last test
    localparam int CMD_CYC   = 5;       // longest command is a load plus gap
    localparam int N_CMDS    = 16 + 2 * (3 * STACK_DEPTH - 1) + N_RAND;
    localparam int CYC_LIMIT = 16 + 8 + CMD_CYC * N_CMDS + 200;

    localparam mat_cmd_t cmd_idle = '{op: op_none, mode: 1'b0};

    logic     clk = 1'b0;
    logic     rst_n;
    mat_cmd_t cmd;
    row_t     data_in;
    matrix_t  write_in;
    logic     matrix_mode;
    matrix_t  peek;
    logic     busy;
    logic     stack_err;

    always #50 clk = ~clk;      // 100 ns period

    matrix_top #(
        .STACK_DEPTH (STACK_DEPTH)
    ) i_matrix_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .data_in     (data_in),
        .write_in    (write_in),
        .matrix_mode (matrix_mode),
        .peek        (peek),
        .busy        (busy),
        .stack_err   (stack_err)
    );

    //////////////////////
    // random source
    //////////////////////

    logic [15:0] lfsr_q;        // galois lfsr with taps 16 14 13 11

    function automatic logic next_bit();
        logic b;
        b      = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b)
            lfsr_q = lfsr_q ^ 16'hB400;
        return b;
    endfunction

    // n fresh bits packed into the low end
    function automatic logic [511:0] rand_bits(input int n);
        logic [511:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[510:0], next_bit()};
        return v;
    endfunction

    //////////////////////
    // reference model
    //////////////////////

    matrix_t mdl_entry [2][STACK_DEPTH];   // [mode][slot]
    int      mdl_cnt [2];                  // depth per stack
    int      mdl_phase;                    // 0 idle, 1..3 next load row
    logic    mdl_load_mode;
    matrix_t mdl_load;                     // rows gathered so far
    logic    exp_err;
    logic    exp_busy;
    matrix_t exp_peek;

    assign exp_busy = (mdl_phase != 0);
    assign exp_peek = mdl_entry[matrix_mode][mdl_cnt[matrix_mode] - 1];

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            mdl_cnt[0]      <= 1;
            mdl_cnt[1]      <= 1;
            mdl_entry[0][0] <= mat_identity;
            mdl_entry[1][0] <= mat_identity;
            mdl_phase       <= 0;
            exp_err         <= 1'b0;
        end
        else
        begin
            exp_err <= 1'b0;
            case (mdl_phase)
                0:
                begin
                    case (cmd.op)
                        op_load_id: mdl_entry[cmd.mode][mdl_cnt[cmd.mode] - 1] <= mat_identity;
                        op_write:   mdl_entry[cmd.mode][mdl_cnt[cmd.mode] - 1] <= write_in;
                        op_load:
                        begin
                            mdl_load.r0   <= data_in;   // row 0 rides with the command
                            mdl_load_mode <= cmd.mode;
                            mdl_phase     <= 1;
                        end
                        op_push:
                        begin
                            if (mdl_cnt[cmd.mode] < STACK_DEPTH)
                            begin
                                mdl_entry[cmd.mode][mdl_cnt[cmd.mode]] <=
                                    mdl_entry[cmd.mode][mdl_cnt[cmd.mode] - 1];
                                mdl_cnt[cmd.mode] <= mdl_cnt[cmd.mode] + 1;
                            end
                            else
                                exp_err <= 1'b1;        // full
                        end
                        op_pop:
                        begin
                            if (mdl_cnt[cmd.mode] > 1)
                                mdl_cnt[cmd.mode] <= mdl_cnt[cmd.mode] - 1;
                            else
                                exp_err <= 1'b1;        // last entry stays
                        end
                        default: ;
                    endcase
                end
                1:
                begin
                    mdl_load.r1 <= data_in;
                    mdl_phase   <= 2;
                end
                2:
                begin
                    mdl_load.r2 <= data_in;
                    mdl_phase   <= 3;
                end
                default:
                begin
                    // whole matrix lands at once with row 3 live
                    mdl_entry[mdl_load_mode][mdl_cnt[mdl_load_mode] - 1] <= '{
                        r0: mdl_load.r0,
                        r1: mdl_load.r1,
                        r2: mdl_load.r2,
                        r3: data_in
                    };
                    mdl_phase <= 0;
                end
            endcase
        end
    end

    //////////////////////
    // checks
    //////////////////////

    string test_name = "reset";

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [511:0] exp_v,
                                   input logic [511:0] act_v);
        $display("FAIL %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        stop_on_error();
    endtask

    a_peek : assert property (@(posedge clk) disable iff (!rst_n) peek == exp_peek)
        else report_mismatch("peek", $sampled(exp_peek), $sampled(peek));

    a_busy : assert property (@(posedge clk) disable iff (!rst_n) busy == exp_busy)
        else report_mismatch("busy", $sampled(exp_busy), $sampled(busy));

    a_err : assert property (@(posedge clk) disable iff (!rst_n) stack_err == exp_err)
        else report_mismatch("stack_err", $sampled(exp_err), $sampled(stack_err));

    // hang guard
    int cycle_cnt = 0;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYC_LIMIT)
        begin
            $display("timeout after %0d cycles, stimulus did not finish", cycle_cnt);
            stop_on_error();
        end
    end

    //////////////////////
    // stimulus
    //////////////////////

    // name switches once the gap cycle of the previous test is checked
    task automatic start_test(input string name);
        @(posedge clk);
        @(negedge clk);
        test_name = name;
    endtask

    // one command and then a gap cycle where peek shows the result
    task automatic issue(input mat_op_e opc, input logic sel_mode, input logic view);
        @(posedge clk);
        cmd         <= '{op: opc, mode: sel_mode};
        matrix_mode <= view;
        data_in     <= row_t'(rand_bits(128));
        write_in    <= matrix_t'(rand_bits(512));
        if (opc == op_load)
        begin
            repeat (3)
            begin
                @(posedge clk);
                cmd     <= cmd_idle;
                data_in <= row_t'(rand_bits(128));  // rows 1..3
            end
        end
        @(posedge clk);
        cmd <= cmd_idle;
    endtask

    task automatic random_cmd();
        logic [2:0] pick;
        mat_op_e    opc;
        logic       sel_mode;
        logic       view;
        pick     = 3'(rand_bits(3));
        opc      = (pick > 3'd5) ? op_none : mat_op_e'(pick);   // 6,7 idle
        sel_mode = 1'(rand_bits(1));
        view     = 1'(rand_bits(1));
        issue(opc, sel_mode, view);
    endtask

    initial
    begin
        lfsr_q      = 16'd52487;
        rst_n       = 1'b0;
        cmd         = cmd_idle;
        data_in     = '0;
        write_in    = '0;
        matrix_mode = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // identity on both stacks
        test_name = "reset";
        @(posedge clk);
        matrix_mode <= 1'b1;
        @(posedge clk);
        matrix_mode <= 1'b0;
        @(posedge clk);

        start_test("load");
        issue(op_load, 1'b0, 1'b0);
        issue(op_none, 1'b0, 1'b1);     // projection untouched
        issue(op_load, 1'b1, 1'b1);
        issue(op_none, 1'b0, 1'b0);

        start_test("push_pop");
        for (int m = 0; m < 2; m++)
        begin
            issue(op_push, 1'(m), 1'(m));
            issue(op_write, 1'(m), 1'(m));      // only the new top changes
            issue(op_none, 1'(m), 1'(1 - m));
            issue(op_pop, 1'(m), 1'(m));        // earlier matrix back
        end

        start_test("write_id");
        for (int m = 0; m < 2; m++)
        begin
            issue(op_write, 1'(m), 1'(m));
            issue(op_load_id, 1'(m), 1'(m));
        end

        start_test("bounds");
        for (int m = 0; m < 2; m++)
        begin
            repeat (STACK_DEPTH - 1)
            begin
                issue(op_push, 1'(m), 1'(m));
                issue(op_write, 1'(m), 1'(m));  // distinct entries
            end
            issue(op_push, 1'(m), 1'(m));       // one too many
            repeat (STACK_DEPTH - 1) issue(op_pop, 1'(m), 1'(m));
            issue(op_pop, 1'(m), 1'(m));        // below depth 1
        end

        start_test("random");
        repeat (N_RAND) random_cmd();
        repeat (4) @(posedge clk);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== logic/matrix_top.sv ====
`timescale 1ns/1ps

module matrix_top #(
    parameter int STACK_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  gl_cmd_pkg::mat_cmd_t   cmd,
    input  gl_matrix_pkg::row_t    data_in,
    input  gl_matrix_pkg::matrix_t write_in,
    input  logic                   matrix_mode,    // peek select only
    output gl_matrix_pkg::matrix_t peek,
    output logic                   busy,
    output logic                   stack_err
);

    import gl_matrix_pkg::*;
    import gl_cmd_pkg::*;

    logic     mv_push, mv_pop, mv_wr;
    logic     pj_push, pj_pop, pj_wr;
    logic     mv_can_push, mv_can_pop;
    logic     pj_can_push, pj_can_pop;
    wr_sel_t  wr_sel;
    logic     row_en;
    row_idx_t row_idx;
    matrix_t  load_mat;     // rows 0..2 held, row 3 live
    matrix_t  wr_data;      // shared overwrite source
    matrix_t  mv_top;
    matrix_t  pj_top;

    //////////////////////
    // control
    //////////////////////

    matrix_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .mv_can_push (mv_can_push),
        .mv_can_pop  (mv_can_pop),
        .pj_can_push (pj_can_push),
        .pj_can_pop  (pj_can_pop),
        .mv_push     (mv_push),
        .mv_pop      (mv_pop),
        .mv_wr       (mv_wr),
        .pj_push     (pj_push),
        .pj_pop      (pj_pop),
        .pj_wr       (pj_wr),
        .wr_sel      (wr_sel),
        .row_en      (row_en),
        .row_idx     (row_idx),
        .busy        (busy),
        .stack_err   (stack_err)
    );

    row_assembler i_row_asm (
        .clk      (clk),
        .rst_n    (rst_n),
        .row_en   (row_en),
        .row_idx  (row_idx),
        .data_in  (data_in),
        .load_mat (load_mat)
    );

    //////////////////////
    // overwrite source
    //////////////////////

    always_comb
    begin
        case (wr_sel)
            wr_sel_load:  wr_data = load_mat;
            wr_sel_write: wr_data = write_in;
            default:      wr_data = mat_identity;  // load identity
        endcase
    end

    //////////////////////
    // stacks
    //////////////////////

    matrix_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) i_mv_stack (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (mv_push),
        .pop      (mv_pop),
        .wr_top   (mv_wr),
        .wr_data  (wr_data),
        .top      (mv_top),
        .can_push (mv_can_push),
        .can_pop  (mv_can_pop)
    );

    matrix_stack #(
        .STACK_DEPTH (STACK_DEPTH)
    ) i_pj_stack (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (pj_push),
        .pop      (pj_pop),
        .wr_top   (pj_wr),
        .wr_data  (wr_data),
        .top      (pj_top),
        .can_push (pj_can_push),
        .can_pop  (pj_can_pop)
    );

    // peek follows the level, not the command mode
    assign peek = matrix_mode ? pj_top : mv_top;

endmodule

// ==== logic/matrix_ctrl.sv ====
`timescale 1ns/1ps

module matrix_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  gl_cmd_pkg::mat_cmd_t cmd,
    input  logic                 mv_can_push,
    input  logic                 mv_can_pop,
    input  logic                 pj_can_push,
    input  logic                 pj_can_pop,
    output logic                 mv_push,
    output logic                 mv_pop,
    output logic                 mv_wr,
    output logic                 pj_push,
    output logic                 pj_pop,
    output logic                 pj_wr,
    output gl_cmd_pkg::wr_sel_t  wr_sel,
    output logic                 row_en,
    output gl_cmd_pkg::row_idx_t row_idx,
    output logic                 busy,
    output logic                 stack_err
);

    import gl_cmd_pkg::*;

    // encoding doubles as the load row number
    typedef enum logic [1:0] {
        st_idle = 2'd0,     // row 0 arrives with the command
        st_row1 = 2'd1,
        st_row2 = 2'd2,
        st_row3 = 2'd3      // commit cycle
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   load_mode_q;    // stack picked by the pending load
    logic   tgt_mode;       // stack steered this cycle
    logic   sel_can_push;
    logic   sel_can_pop;
    logic   push_req;
    logic   pop_req;
    logic   wr_req;
    logic   err_d;

    //////////////////////
    // decode
    //////////////////////

    assign tgt_mode     = (state_q == st_idle) ? cmd.mode : load_mode_q;
    assign sel_can_push = tgt_mode ? pj_can_push : mv_can_push;
    assign sel_can_pop  = tgt_mode ? pj_can_pop  : mv_can_pop;

    always_comb
    begin
        state_d  = state_q;
        push_req = 1'b0;
        pop_req  = 1'b0;
        wr_req   = 1'b0;
        wr_sel   = wr_sel_id;
        row_en   = 1'b0;
        err_d    = 1'b0;
        case (state_q)
            st_idle:
            begin
                case (cmd.op)
                    op_load_id: wr_req = 1'b1;  // identity is the default source
                    op_write:
                    begin
                        wr_req = 1'b1;
                        wr_sel = wr_sel_write;
                    end
                    op_load:
                    begin
                        row_en  = 1'b1;         // capture row 0 now
                        state_d = st_row1;
                    end
                    op_push:
                    begin
                        push_req = sel_can_push;
                        err_d    = !sel_can_push;   // full, drop it
                    end
                    op_pop:
                    begin
                        pop_req = sel_can_pop;
                        err_d   = !sel_can_pop;     // last entry stays
                    end
                    default: ;                  // op_none
                endcase
            end
            st_row1:
            begin
                row_en  = 1'b1;
                state_d = st_row2;
            end
            st_row2:
            begin
                row_en  = 1'b1;
                state_d = st_row3;
            end
            st_row3:
            begin
                wr_req  = 1'b1;             // row 3 goes straight through
                wr_sel  = wr_sel_load;
                state_d = st_idle;
            end
            default: state_d = st_idle;
        endcase
    end

    // steer requests to one stack
    assign mv_push = push_req && !tgt_mode;
    assign mv_pop  = pop_req  && !tgt_mode;
    assign mv_wr   = wr_req   && !tgt_mode;
    assign pj_push = push_req &&  tgt_mode;
    assign pj_pop  = pop_req  &&  tgt_mode;
    assign pj_wr   = wr_req   &&  tgt_mode;

    assign row_idx = row_idx_t'(state_q);
    assign busy    = (state_q != st_idle);  // rows 1..3 pending

    //////////////////////
    // state
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q     <= st_idle;
            load_mode_q <= 1'b0;
            stack_err   <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            stack_err <= err_d;             // one cycle pulse
            if (state_q == st_idle && cmd.op == op_load)
                load_mode_q <= cmd.mode;
        end
    end

    // a stack never sees both depth strobes at once
    a_no_push_pop : assert property (@(posedge clk) disable iff (!rst_n)
        !((mv_push || pj_push) && (mv_pop || pj_pop)));

endmodule

// ==== logic/matrix_stack.sv ====
`timescale 1ns/1ps

module matrix_stack #(
    parameter int STACK_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic                   pop,
    input  logic                   wr_top,
    input  gl_matrix_pkg::matrix_t wr_data,
    output gl_matrix_pkg::matrix_t top,
    output logic                   can_push,
    output logic                   can_pop
);

    import gl_matrix_pkg::*;

    // count runs 1..STACK_DEPTH, slots 0..STACK_DEPTH-1
    localparam int CNT_W = $clog2(STACK_DEPTH + 1);
    localparam int IDX_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [IDX_W-1:0] idx_t;

    matrix_t entry [STACK_DEPTH];  // entry 0 is the bottom
    cnt_t    count;                 // current depth
    idx_t    top_idx;               // count - 1
    idx_t    new_idx;               // slot above top

    //////////////////////
    // pointers and flags
    //////////////////////

    assign top_idx  = idx_t'(count - cnt_t'(1));
    assign new_idx  = idx_t'(count);       // only used below depth limit
    assign can_push = (count < cnt_t'(STACK_DEPTH));
    assign can_pop  = (count > cnt_t'(1));

    assign top = entry[top_idx];          // combinational peek

    //////////////////////
    // update
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            count    <= cnt_t'(1);
            entry[0] <= mat_identity;   // fresh stack holds identity
        end
        else
        begin
            if (push)
            begin
                entry[new_idx] <= entry[top_idx];   // duplicate top
                count          <= count + cnt_t'(1);
            end
            else if (pop)
            begin
                count <= count - cnt_t'(1);     // old slot left stale
            end
            else if (wr_top)
            begin
                entry[top_idx] <= wr_data;
            end
        end
    end

    //////////////////////
    // checks
    //////////////////////

    // controller must filter out illegal depth changes
    a_push_legal : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> can_push);

    a_pop_legal : assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> can_pop);

endmodule

// ==== logic/row_assembler.sv ====
`timescale 1ns/1ps

module row_assembler (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   row_en,
    input  gl_cmd_pkg::row_idx_t   row_idx,
    input  gl_matrix_pkg::row_t    data_in,
    output gl_matrix_pkg::matrix_t load_mat
);

    import gl_matrix_pkg::*;

    row_t row0_q;   // captured with the op_load strobe
    row_t row1_q;
    row_t row2_q;

    //////////////////////
    // capture rows 0..2
    //////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            row0_q <= '0;
            row1_q <= '0;
            row2_q <= '0;
        end
        else if (row_en)
        begin
            case (row_idx)
                2'd0:    row0_q <= data_in;
                2'd1:    row1_q <= data_in;
                2'd2:    row2_q <= data_in;
                default: ;          // row 3 is never stored
            endcase
        end
    end

    // last row live, so the commit lands in the row 3 cycle
    assign load_mat = '{
        r0: row0_q,
        r1: row1_q,
        r2: row2_q,
        r3: data_in
    };

endmodule

// ==== logic/gl_cmd_pkg.sv ====
package gl_cmd_pkg;

    //////////////////////
    // command encoding
    //////////////////////

    typedef enum logic [2:0] {
        op_none    = 3'd0,  // idle cycle
        op_load_id = 3'd1,  // top <= identity
        op_load    = 3'd2,  // top <= four rows off data_in
        op_push    = 3'd3,  // duplicate top
        op_pop     = 3'd4,  // drop top
        op_write   = 3'd5   // top <= write_in
    } mat_op_e;

    // one strobe per cycle, op_none when nothing to do
    typedef struct packed {
        mat_op_e op;
        logic    mode;      // 0 modelview, 1 projection
    } mat_cmd_t;

    typedef logic [1:0] row_idx_t;      // load row 0..3

    //////////////////////
    // top overwrite source
    //////////////////////

    typedef logic [1:0] wr_sel_t;

    localparam wr_sel_t wr_sel_id    = 2'd0;   // identity constant
    localparam wr_sel_t wr_sel_load  = 2'd1;   // assembled load matrix
    localparam wr_sel_t wr_sel_write = 2'd2;   // external write_in

endpackage

// ==== logic/gl_matrix_pkg.sv ====
package gl_matrix_pkg;

    //////////////////////
    // matrix data widths
    //////////////////////

    localparam int elem_w    = 32;              // ieee single
    localparam int row_elems = 4;
    localparam int row_w     = elem_w * row_elems;  // 128 bits per row

    typedef logic [elem_w-1:0] elem_t;          // one float element
    typedef logic [row_w-1:0]  row_t;           // element 0 in the top word

    // whole 4x4 matrix, r0 sits in the most significant 128 bits
    typedef struct packed {
        row_t r0;
        row_t r1;
        row_t r2;
        row_t r3;
    } matrix_t;

    //////////////////////
    // constants
    //////////////////////

    localparam elem_t elem_one  = 32'h3F80_0000;    // 1.0f
    localparam elem_t elem_zero = 32'h0000_0000;    // +0.0f

    // 1.0 on the diagonal only
    localparam matrix_t mat_identity = '{
        r0: {elem_one,  elem_zero, elem_zero, elem_zero},
        r1: {elem_zero, elem_one,  elem_zero, elem_zero},
        r2: {elem_zero, elem_zero, elem_one,  elem_zero},
        r3: {elem_zero, elem_zero, elem_zero, elem_one}
    };

endpackage
